/* design/oflow_pkg.sv */
package oflow_pkg;

	// ----------------------------------------
	// box geometry
	// ----------------------------------------
	localparam int COORD_W = 8;                // one coordinate
	localparam int BBOX_W  = 4 * COORD_W;      // x, y, w, h packed
	localparam int X_LSB   = 0;                // x sits lowest
	localparam int Y_LSB   = X_LSB + COORD_W;
	localparam int W_LSB   = Y_LSB + COORD_W;
	localparam int H_LSB   = W_LSB + COORD_W;  // h sits highest

	// cost arithmetic
	localparam int WEIGHT_W = 4;
	localparam int COST_W   = 14;  // 4 * 255 * 15 still fits

	// track storage
	localparam int ID_W       = 8;
	localparam int MAX_BBOXES = 8;                    // records kept per frame
	localparam int IDX_W      = $clog2(MAX_BBOXES);
	localparam int CNT_W      = IDX_W + 1;            // needs to reach MAX_BBOXES
	localparam int CONF_W     = 8;                    // conflict counter

	// ----------------------------------------
	// configuration bus
	// ----------------------------------------
	localparam int CFG_ADDR_W = 3;
	localparam int CFG_DATA_W = 16;

	localparam logic [CFG_ADDR_W-1:0] CFG_WX  = 3'd0;
	localparam logic [CFG_ADDR_W-1:0] CFG_WY  = 3'd1;
	localparam logic [CFG_ADDR_W-1:0] CFG_WW  = 3'd2;
	localparam logic [CFG_ADDR_W-1:0] CFG_WH  = 3'd3;
	localparam logic [CFG_ADDR_W-1:0] CFG_THR = 3'd4;

	localparam logic [WEIGHT_W-1:0] WEIGHT_RST = 4'd1;   // equal weights out of reset
	localparam logic [COST_W-1:0]   THR_RST    = 14'd64;

	// tracker fsm encoding
	localparam int STATE_W = 2;
	localparam logic [STATE_W-1:0] S_IDLE   = 2'd0;
	localparam logic [STATE_W-1:0] S_SCAN   = 2'd1;
	localparam logic [STATE_W-1:0] S_DECIDE = 2'd2;
	localparam logic [STATE_W-1:0] S_SWAP   = 2'd3;

endpackage

/* design/oflow_if.sv */
`timescale 1ns/1ps

// weights and threshold, regs -> pe
interface oflow_weight_if import oflow_pkg::*; ();
	logic [WEIGHT_W-1:0] wx;
	logic [WEIGHT_W-1:0] wy;
	logic [WEIGHT_W-1:0] ww;
	logic [WEIGHT_W-1:0] wh;
	logic [COST_W-1:0]   thr;  // match threshold

	modport cfg (output wx, wy, ww, wh, thr);
	modport pe  (input  wx, wy, ww, wh, thr);
endinterface

// frame store access
interface oflow_mem_if import oflow_pkg::*; ();
	logic [IDX_W-1:0]  rd_idx;      // prev-frame read address
	logic              wr_en;
	logic [IDX_W-1:0]  wr_idx;
	logic [BBOX_W-1:0] wr_bbox;
	logic [ID_W-1:0]   wr_id;
	logic              swap;        // frame end strobe
	logic [BBOX_W-1:0] rd_bbox;     // combinational read
	logic [ID_W-1:0]   rd_id;
	logic [CNT_W-1:0]  prev_count;  // valid records in prev bank

	modport ctrl (output rd_idx, wr_en, wr_idx, wr_bbox, wr_id, swap, input rd_id, prev_count);
	modport mem  (input rd_idx, wr_en, wr_idx, wr_bbox, wr_id, swap,
	              output rd_bbox, rd_id, prev_count);
	modport pe   (input rd_bbox);
endinterface

/* design/oflow_weight_regs.sv */
`timescale 1ns/1ps

module oflow_weight_regs import oflow_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  cfg_we_i,
	input  logic [CFG_ADDR_W-1:0] cfg_addr_i,
	input  logic [CFG_DATA_W-1:0] cfg_data_i,
	oflow_weight_if.cfg           w
);

	// ----------------------------------------
	// register file
	// ----------------------------------------
	// weights use the low nibble, threshold the low cost bits
	always_ff @(posedge clk) begin
		if (rst_i) begin
			w.wx  <= WEIGHT_RST;
			w.wy  <= WEIGHT_RST;
			w.ww  <= WEIGHT_RST;
			w.wh  <= WEIGHT_RST;
			w.thr <= THR_RST;
		end else if (cfg_we_i) begin
			case (cfg_addr_i)
				CFG_WX:  w.wx  <= cfg_data_i[WEIGHT_W-1:0];
				CFG_WY:  w.wy  <= cfg_data_i[WEIGHT_W-1:0];
				CFG_WW:  w.ww  <= cfg_data_i[WEIGHT_W-1:0];
				CFG_WH:  w.wh  <= cfg_data_i[WEIGHT_W-1:0];
				CFG_THR: w.thr <= cfg_data_i[COST_W-1:0];
				default: begin
					// unmapped address, write dropped
				end
			endcase
		end
	end

endmodule

/* design/oflow_frame_mem.sv */
`timescale 1ns/1ps

module oflow_frame_mem import oflow_pkg::*; (
	input logic      clk,
	input logic      rst_i,
	oflow_mem_if.mem m
);

	// ----------------------------------------
	// storage
	// ----------------------------------------
	logic [BBOX_W-1:0] bbox_q [2][MAX_BBOXES];  // box per bank and slot
	logic [ID_W-1:0]   id_q   [2][MAX_BBOXES];  // track id per bank and slot

	logic             cur_bank;      // bank being filled this frame
	logic [CNT_W-1:0] count;         // records written this frame
	logic [CNT_W-1:0] prev_count_q;  // records left by last frame

	// record write into the current bank
	always_ff @(posedge clk) begin
		if (m.wr_en) begin
			bbox_q[cur_bank][m.wr_idx] <= m.wr_bbox;
			id_q[cur_bank][m.wr_idx]   <= m.wr_id;
		end
	end

	// ----------------------------------------
	// bank select and counts
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			cur_bank     <= 1'b0;
			count        <= '0;
			prev_count_q <= '0;  // nothing to match on the first frame
		end else if (m.swap) begin
			cur_bank     <= ~cur_bank;  // current frame becomes previous
			prev_count_q <= count;
			count        <= '0;
		end else if (m.wr_en && (count != CNT_W'(MAX_BBOXES))) begin
			count <= count + 1'b1;  // saturates at a full bank
		end
	end

	// reads always come from the previous bank
	assign m.rd_bbox    = bbox_q[~cur_bank][m.rd_idx];
	assign m.rd_id      = id_q[~cur_bank][m.rd_idx];
	assign m.prev_count = prev_count_q;

endmodule

/* design/oflow_match_pe.sv */
`timescale 1ns/1ps

module oflow_match_pe import oflow_pkg::*; (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              scan_start_i,  // clears best at the edge
	input  logic              scan_step_i,   // one prev box per cycle
	input  logic [IDX_W-1:0]  scan_idx_i,
	input  logic [BBOX_W-1:0] new_bbox_i,
	oflow_weight_if.pe        w,
	oflow_mem_if.pe           m,
	output logic [IDX_W-1:0]  best_idx_o,
	output logic              hit_o
);

	function automatic logic [COORD_W-1:0] abs_diff(input logic [COORD_W-1:0] a,
	                                                input logic [COORD_W-1:0] b);
		return (a > b) ? (a - b) : (b - a);
	endfunction

	// ----------------------------------------
	// cost of new box vs current prev box
	// ----------------------------------------
	logic [COORD_W-1:0] dx;
	logic [COORD_W-1:0] dy;
	logic [COORD_W-1:0] dw;
	logic [COORD_W-1:0] dh;
	logic [COST_W-1:0]  cost;
	logic [COST_W-1:0]  best_cost;
	logic               best_valid;  // at least one step seen

	assign dx = abs_diff(new_bbox_i[X_LSB +: COORD_W], m.rd_bbox[X_LSB +: COORD_W]);
	assign dy = abs_diff(new_bbox_i[Y_LSB +: COORD_W], m.rd_bbox[Y_LSB +: COORD_W]);
	assign dw = abs_diff(new_bbox_i[W_LSB +: COORD_W], m.rd_bbox[W_LSB +: COORD_W]);
	assign dh = abs_diff(new_bbox_i[H_LSB +: COORD_W], m.rd_bbox[H_LSB +: COORD_W]);

	// max term 255*15, four of them stay below 2^14
	assign cost = COST_W'(dx) * COST_W'(w.wx)
	            + COST_W'(dy) * COST_W'(w.wy)
	            + COST_W'(dw) * COST_W'(w.ww)
	            + COST_W'(dh) * COST_W'(w.wh);

	// ----------------------------------------
	// running minimum
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i)
			best_valid <= 1'b0;
		else if (scan_start_i)
			best_valid <= 1'b0;
		else if (scan_step_i)
			best_valid <= 1'b1;
	end

	// strictly lower only, so ties keep the lowest index
	always_ff @(posedge clk) begin
		if (scan_step_i && (!best_valid || (cost < best_cost))) begin
			best_cost  <= cost;
			best_idx_o <= scan_idx_i;
		end
	end

	assign hit_o = best_valid && (best_cost <= w.thr);  // inclusive threshold

endmodule

/* design/oflow_track_ctrl.sv */
`timescale 1ns/1ps

module oflow_track_ctrl import oflow_pkg::*; (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              bbox_valid_i,
	input  logic [BBOX_W-1:0] bbox_i,
	input  logic              frame_end_i,
	oflow_mem_if.ctrl         m,
	input  logic [IDX_W-1:0]  best_idx_i,
	input  logic              hit_i,
	output logic              scan_start_o,
	output logic              scan_step_o,
	output logic [IDX_W-1:0]  scan_idx_o,
	output logic [BBOX_W-1:0] new_bbox_o,
	output logic              ready_o,
	output logic              id_valid_o,
	output logic [ID_W-1:0]   id_o,
	output logic              frame_done_o,
	output logic [CONF_W-1:0] conflict_cnt_o
);

	logic [STATE_W-1:0]    state;
	logic [IDX_W-1:0]      scan_idx;
	logic [MAX_BBOXES-1:0] claim;     // prev entries already reused
	logic [ID_W-1:0]       next_id;   // next fresh id
	logic [CNT_W-1:0]      cur_cnt;   // boxes stored this frame
	logic [CONF_W-1:0]     conf_cnt;
	logic                  accept_box;
	logic                  accept_end;
	logic                  last_step;
	logic                  reuse;
	logic                  conflict;

	// ----------------------------------------
	// decode
	// ----------------------------------------
	assign ready_o    = (state == S_IDLE);
	assign accept_end = ready_o && frame_end_i;                   // frame end wins
	assign accept_box = ready_o && bbox_valid_i && !frame_end_i;
	assign last_step  = ((CNT_W'(scan_idx) + CNT_W'(1)) == m.prev_count);
	assign reuse      = hit_i && !claim[best_idx_i];
	assign conflict   = hit_i && claim[best_idx_i];  // no second-best fallback

	assign scan_start_o   = accept_box;
	assign scan_step_o    = (state == S_SCAN);
	assign scan_idx_o     = scan_idx;
	assign id_valid_o     = (state == S_DECIDE);
	assign frame_done_o   = (state == S_SWAP);
	assign id_o           = reuse ? m.rd_id : next_id;
	assign conflict_cnt_o = conf_cnt;

	// decide reads the winner's id, scan walks the bank
	assign m.rd_idx  = (state == S_DECIDE) ? best_idx_i : scan_idx;
	assign m.wr_en   = id_valid_o && (cur_cnt < CNT_W'(MAX_BBOXES));  // ninth box on not stored
	assign m.wr_idx  = cur_cnt[IDX_W-1:0];
	assign m.wr_bbox = new_bbox_o;
	assign m.wr_id   = id_o;
	assign m.swap    = frame_done_o;

	// box under test, held for scan and write
	always_ff @(posedge clk) begin
		if (accept_box)
			new_bbox_o <= bbox_i;
	end

	// ----------------------------------------
	// fsm and counters
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state    <= S_IDLE;
			scan_idx <= '0;
			claim    <= '0;
			next_id  <= ID_W'(1);  // id 0 never issued
			cur_cnt  <= '0;
			conf_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (accept_end) begin
						state <= S_SWAP;
					end else if (accept_box) begin
						scan_idx <= '0;
						state    <= (m.prev_count == '0) ? S_DECIDE : S_SCAN;  // empty prev frame
					end
				end
				S_SCAN: begin
					scan_idx <= scan_idx + 1'b1;
					if (last_step)
						state <= S_DECIDE;
				end
				S_DECIDE: begin
					if (reuse)
						claim[best_idx_i] <= 1'b1;
					else
						next_id <= (next_id == '1) ? ID_W'(1) : next_id + 1'b1;  // 255 wraps to 1
					if (conflict && (conf_cnt != '1))
						conf_cnt <= conf_cnt + 1'b1;  // saturating
					if (m.wr_en)
						cur_cnt <= cur_cnt + 1'b1;
					state <= S_IDLE;
				end
				default: begin
					// swap cycle, new frame starts clean
					claim   <= '0;
					cur_cnt <= '0;
					state   <= S_IDLE;
				end
			endcase
		end
	end

endmodule

/* design/oflow_core.sv */
`timescale 1ns/1ps

module oflow_core import oflow_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_i,
	// configuration
	input  logic                  cfg_we_i,
	input  logic [CFG_ADDR_W-1:0] cfg_addr_i,
	input  logic [CFG_DATA_W-1:0] cfg_data_i,
	// box stream
	input  logic                  bbox_valid_i,
	input  logic [BBOX_W-1:0]     bbox_i,
	input  logic                  frame_end_i,
	output logic                  ready_o,
	// results
	output logic                  id_valid_o,
	output logic [ID_W-1:0]       id_o,
	output logic                  frame_done_o,
	output logic [CONF_W-1:0]     conflict_cnt_o
);

	// ----------------------------------------
	// internal links
	// ----------------------------------------
	logic              scan_start;
	logic              scan_step;
	logic [IDX_W-1:0]  scan_idx;
	logic [BBOX_W-1:0] new_bbox;
	logic [IDX_W-1:0]  best_idx;
	logic              hit;

	oflow_weight_if weight_if ();
	oflow_mem_if    mem_if ();

	// ----------------------------------------
	// instances
	// ----------------------------------------
	oflow_weight_regs oflow_weight_regs (
		.clk        (clk),
		.rst_i      (rst_i),
		.cfg_we_i   (cfg_we_i),
		.cfg_addr_i (cfg_addr_i),
		.cfg_data_i (cfg_data_i),
		.w          (weight_if.cfg)
	);

	oflow_frame_mem oflow_frame_mem (
		.clk   (clk),
		.rst_i (rst_i),
		.m     (mem_if.mem)
	);

	oflow_match_pe oflow_match_pe (
		.clk          (clk),
		.rst_i        (rst_i),
		.scan_start_i (scan_start),
		.scan_step_i  (scan_step),
		.scan_idx_i   (scan_idx),
		.new_bbox_i   (new_bbox),
		.w            (weight_if.pe),
		.m            (mem_if.pe),
		.best_idx_o   (best_idx),
		.hit_o        (hit)
	);

	oflow_track_ctrl oflow_track_ctrl (
		.clk            (clk),
		.rst_i          (rst_i),
		.bbox_valid_i   (bbox_valid_i),
		.bbox_i         (bbox_i),
		.frame_end_i    (frame_end_i),
		.m              (mem_if.ctrl),
		.best_idx_i     (best_idx),
		.hit_i          (hit),
		.scan_start_o   (scan_start),
		.scan_step_o    (scan_step),
		.scan_idx_o     (scan_idx),
		.new_bbox_o     (new_bbox),
		.ready_o        (ready_o),
		.id_valid_o     (id_valid_o),
		.id_o           (id_o),
		.frame_done_o   (frame_done_o),
		.conflict_cnt_o (conflict_cnt_o)
	);

endmodule

/* test/oflow_core_props.sv */
`timescale 1ns/1ps

module oflow_core_props import oflow_pkg::*; (
	input logic            clk,
	input logic            rst_i,
	input logic            ready_o,
	input logic            id_valid_o,
	input logic [ID_W-1:0] id_o,
	input logic            frame_done_o
);

	int fail_cnt = 0;  // summed into the final verdict

	// ----------------------------------------
	// pulse shape
	// ----------------------------------------
	id_pulse_a: assert property (@(posedge clk) disable iff (rst_i) id_valid_o |=> !id_valid_o)
		else begin
			$error("id_valid_o high on two cycles in a row");
			fail_cnt = fail_cnt + 1;
		end

	done_pulse_a: assert property (@(posedge clk) disable iff (rst_i)
		frame_done_o |=> !frame_done_o)
		else begin
			$error("frame_done_o high on two cycles in a row");
			fail_cnt = fail_cnt + 1;
		end

	// core is busy while it reports a result
	busy_a: assert property (@(posedge clk) disable iff (rst_i) id_valid_o |-> !ready_o)
		else begin
			$error("ready_o high together with id_valid_o");
			fail_cnt = fail_cnt + 1;
		end

	// id 0 is never handed out
	id_nonzero_a: assert property (@(posedge clk) disable iff (rst_i) id_valid_o |-> (id_o != '0))
		else begin
			$error("id_o is zero on a valid id");
			fail_cnt = fail_cnt + 1;
		end

endmodule

/* test/oflow_core_checker.sv */
`timescale 1ns/1ps

module oflow_core_checker import oflow_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  cfg_we_i,
	input  logic [CFG_ADDR_W-1:0] cfg_addr_i,
	input  logic [CFG_DATA_W-1:0] cfg_data_i,
	input  logic                  bbox_valid_i,
	input  logic [BBOX_W-1:0]     bbox_i,
	input  logic                  frame_end_i,
	input  logic                  ready_o,
	input  logic                  id_valid_o,
	input  logic [ID_W-1:0]       id_o,
	input  logic                  frame_done_o,
	input  logic [CONF_W-1:0]     conflict_cnt_o,
	output int                    err_cnt_o,
	output int                    chk_cnt_o
);

	// ----------------------------------------
	// model state
	// ----------------------------------------
	logic [BBOX_W-1:0] prev_box [MAX_BBOXES];
	logic [BBOX_W-1:0] cur_box  [MAX_BBOXES];
	int                prev_id  [MAX_BBOXES];
	int                cur_id   [MAX_BBOXES];
	bit                claimed  [MAX_BBOXES];  // prev entries reused this frame
	int                wt [4];                 // x, y, w, h weights
	int                thr;
	int                prev_n;
	int                cur_n;
	int                fresh_id;
	int                conflicts;
	int                exp_id;
	int                exp_conf;
	bit                id_due;                 // box in flight
	bit                done_due;               // frame end in flight
	bit                was_rst = 1'b0;
	int                errors = 0;
	int                checks = 0;

	assign err_cnt_o = errors;
	assign chk_cnt_o = checks;

	function automatic int coord_gap(input logic [BBOX_W-1:0] a, input logic [BBOX_W-1:0] b,
	                                 input int lsb);
		int d;
		d = int'(a[lsb +: COORD_W]) - int'(b[lsb +: COORD_W]);
		return (d < 0) ? -d : d;
	endfunction

	function automatic int pair_cost(input logic [BBOX_W-1:0] a, input logic [BBOX_W-1:0] b);
		return wt[0] * coord_gap(a, b, X_LSB) + wt[1] * coord_gap(a, b, Y_LSB)
		     + wt[2] * coord_gap(a, b, W_LSB) + wt[3] * coord_gap(a, b, H_LSB);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	// ----------------------------------------
	// one accepted box
	// ----------------------------------------
	task automatic model_box(input logic [BBOX_W-1:0] b);
		int best;
		int best_cost;
		int c;
		best = -1;
		best_cost = 0;
		for (int i = 0; i < prev_n; i++) begin
			c = pair_cost(b, prev_box[i]);
			if (best < 0 || c < best_cost) begin  // first lowest wins ties
				best = i;
				best_cost = c;
			end
		end
		exp_conf = conflicts;  // counter moves after the pulse
		if (best >= 0 && best_cost <= thr && !claimed[best]) begin
			exp_id = prev_id[best];
			claimed[best] = 1'b1;
		end else begin
			exp_id = fresh_id;
			fresh_id = (fresh_id == (1 << ID_W) - 1) ? 1 : fresh_id + 1;
			if (best >= 0 && best_cost <= thr && conflicts < (1 << CONF_W) - 1)
				conflicts++;  // claimed winner and no second-best
		end
		if (cur_n < MAX_BBOXES) begin
			cur_box[cur_n] = b;
			cur_id[cur_n] = exp_id;
			cur_n++;
		end
		id_due = 1'b1;
	endtask

	always @(posedge clk) begin
		if (rst_i) begin
			for (int k = 0; k < 4; k++)
				wt[k] = int'(WEIGHT_RST);
			thr = int'(THR_RST);
			prev_n = 0;
			cur_n = 0;
			fresh_id = 1;
			conflicts = 0;
			id_due = 1'b0;
			done_due = 1'b0;
			for (int k = 0; k < MAX_BBOXES; k++)
				claimed[k] = 1'b0;
		end else begin
			if (was_rst) begin  // first cycle out of reset
				check_value("ready_o", 32'(ready_o), 32'd1);
				check_value("id_valid_o", 32'(id_valid_o), 32'd0);
				check_value("frame_done_o", 32'(frame_done_o), 32'd0);
				check_value("conflict_cnt_o", 32'(conflict_cnt_o), 32'd0);
			end
			if (id_valid_o && !id_due) begin
				errors++;
				$display("id_valid_o came with no box in flight at %0t", $time);
			end else if (id_valid_o) begin
				check_value("id_o", 32'(id_o), 32'(exp_id));
				check_value("conflict_cnt_o", 32'(conflict_cnt_o), 32'(exp_conf));
				id_due = 1'b0;
			end
			// frame_done_o belongs in the cycle right after the frame end
			if (frame_done_o && !done_due) begin
				errors++;
				$display("frame_done_o came with no frame end in flight at %0t", $time);
			end else if (frame_done_o) begin
				check_value("conflict_cnt_o", 32'(conflict_cnt_o), 32'(conflicts));
			end else if (done_due) begin
				errors++;
				$display("frame_done_o missing in the cycle after a frame end at %0t", $time);
			end
			done_due = 1'b0;
			// config mirror
			if (cfg_we_i) begin
				case (cfg_addr_i)
					CFG_WX:  wt[0] = int'(cfg_data_i[WEIGHT_W-1:0]);
					CFG_WY:  wt[1] = int'(cfg_data_i[WEIGHT_W-1:0]);
					CFG_WW:  wt[2] = int'(cfg_data_i[WEIGHT_W-1:0]);
					CFG_WH:  wt[3] = int'(cfg_data_i[WEIGHT_W-1:0]);
					CFG_THR: thr = int'(cfg_data_i[COST_W-1:0]);
					default: ;
				endcase
			end
			if (ready_o && frame_end_i) begin  // frame end beats a box
				for (int k = 0; k < cur_n; k++) begin
					prev_box[k] = cur_box[k];
					prev_id[k] = cur_id[k];
				end
				for (int k = 0; k < MAX_BBOXES; k++)
					claimed[k] = 1'b0;
				prev_n = cur_n;
				cur_n = 0;
				done_due = 1'b1;
			end else if (ready_o && bbox_valid_i) begin
				model_box(bbox_i);
			end
		end
		was_rst = rst_i;
	end

endmodule

/* test/oflow_core_tb.sv */
`timescale 1ns/1ps

module oflow_core_tb import oflow_pkg::*; ();

	localparam int NUM_FRAMES = 80;
	localparam int WAIT_LIMIT = 64;  // well past the longest scan in cycles
	localparam int MAX_SENT   = 10;  // most boxes sent in one frame

	logic                  clk;
	logic                  rst_i;
	logic                  cfg_we_i;
	logic [CFG_ADDR_W-1:0] cfg_addr_i;
	logic [CFG_DATA_W-1:0] cfg_data_i;
	logic                  bbox_valid_i;
	logic [BBOX_W-1:0]     bbox_i;
	logic                  frame_end_i;
	logic                  ready_o;
	logic                  id_valid_o;
	logic [ID_W-1:0]       id_o;
	logic                  frame_done_o;
	logic [CONF_W-1:0]     conflict_cnt_o;
	int                    err_cnt;
	int                    chk_cnt;

	logic [31:0]       lfsr_q;
	int                timeouts;
	logic [BBOX_W-1:0] last_frame [MAX_SENT];  // every box sent in the previous frame
	logic [BBOX_W-1:0] this_frame [MAX_SENT];
	int                last_n;
	int                this_n;

	oflow_core oflow_core_i (.*);

	oflow_core_checker checker_i (.*, .err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt));

	bind oflow_core oflow_core_props oflow_core_props_i (
		.clk          (clk),
		.rst_i        (rst_i),
		.ready_o      (ready_o),
		.id_valid_o   (id_valid_o),
		.id_o         (id_o),
		.frame_done_o (frame_done_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// fibonacci lfsr with taps 32 22 2 1 and one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// random box, exact copy of a sent box, or a nudged copy
	function automatic logic [BBOX_W-1:0] make_box();
		logic [BBOX_W-1:0]  b;
		logic [1:0]         kind;
		logic [COORD_W-1:0] off;
		kind = 2'(rand_bits(2));
		if (last_n == 0 || kind == 2'd0)
			return rand_bits(BBOX_W);
		b = last_frame[int'(rand_bits(4)) % last_n];  // boxes past the eighth too
		if (kind == 2'd1)
			return b;
		for (int k = 0; k < 4; k++) begin
			off = COORD_W'(rand_bits(3));  // up to 7 either way
			if (rand_bits(1) != 0)
				b[k*COORD_W +: COORD_W] = b[k*COORD_W +: COORD_W] + off;
			else
				b[k*COORD_W +: COORD_W] = b[k*COORD_W +: COORD_W] - off;
		end
		return b;
	endfunction

	// ----------------------------------------
	// bus tasks
	// ----------------------------------------
	task automatic wait_ready();
		int t;
		t = 0;
		@(posedge clk);
		while (!ready_o && t < WAIT_LIMIT) begin
			@(posedge clk);
			t++;
		end
		if (!ready_o) begin
			$display("ready_o stayed low for %0d cycles at %0t", WAIT_LIMIT, $time);
			timeouts++;
		end
	endtask

	task automatic send_box(input logic [BBOX_W-1:0] b);
		int t;
		wait_ready();
		if (timeouts == 0) begin
			bbox_valid_i <= 1'b1;
			bbox_i       <= b;
			@(posedge clk);
			bbox_valid_i <= 1'b0;
			t = 0;
			do begin
				@(posedge clk);
				t++;
			end while (!id_valid_o && t < WAIT_LIMIT);
			if (!id_valid_o) begin
				$display("no id_valid_o after a box at %0t", $time);
				timeouts++;
			end
		end
	endtask

	task automatic end_frame();
		int t;
		wait_ready();
		if (timeouts == 0) begin
			frame_end_i  <= 1'b1;
			bbox_valid_i <= (rand_bits(2) == 0);  // a box alongside gets dropped
			bbox_i       <= rand_bits(BBOX_W);
			@(posedge clk);
			frame_end_i  <= 1'b0;
			bbox_valid_i <= 1'b0;
			t = 0;
			do begin
				@(posedge clk);
				t++;
			end while (!frame_done_o && t < WAIT_LIMIT);
			if (!frame_done_o) begin
				$display("no frame_done_o after a frame end at %0t", $time);
				timeouts++;
			end
		end
	endtask

	task automatic write_reg(input logic [CFG_ADDR_W-1:0] a, input logic [CFG_DATA_W-1:0] d);
		cfg_we_i   <= 1'b1;
		cfg_addr_i <= a;
		cfg_data_i <= d;
		@(posedge clk);
		cfg_we_i   <= 1'b0;
	endtask

	// new weights, junk in the upper data bits, plus one unmapped write
	task automatic write_config();
		logic [CFG_DATA_W-1:0] d;
		write_reg(CFG_WX, CFG_DATA_W'(rand_bits(16)));
		write_reg(CFG_WY, CFG_DATA_W'(rand_bits(16)));
		write_reg(CFG_WW, CFG_DATA_W'(rand_bits(16)));
		write_reg(CFG_WH, CFG_DATA_W'(rand_bits(16)));
		d = CFG_DATA_W'(rand_bits(9));
		d[15:14] = 2'(rand_bits(2));
		write_reg(CFG_THR, d);
		write_reg(CFG_ADDR_W'(5 + int'(rand_bits(3)) % 3), CFG_DATA_W'(rand_bits(16)));
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		int                n_boxes;
		logic [BBOX_W-1:0] b;
		lfsr_q       = 32'hb5676bb0;
		timeouts     = 0;
		last_n       = 0;
		rst_i        = 1'b1;
		cfg_we_i     = 1'b0;
		cfg_addr_i   = '0;
		cfg_data_i   = '0;
		bbox_valid_i = 1'b0;
		bbox_i       = '0;
		frame_end_i  = 1'b0;
		repeat (2) @(posedge clk);
		rst_i <= 1'b0;
		for (int f = 0; f < NUM_FRAMES && timeouts == 0; f++) begin
			if (f % 8 == 7)
				write_config();  // first frames run on reset weights
			n_boxes = int'(rand_bits(4)) % (MAX_SENT + 1);
			this_n = 0;
			for (int i = 0; i < n_boxes; i++) begin
				b = make_box();
				send_box(b);
				this_frame[this_n] = b;
				this_n++;
			end
			end_frame();
			last_frame = this_frame;
			last_n = this_n;
		end
		repeat (2) @(posedge clk);  // checker sees the last pulse
		$display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
		         chk_cnt, err_cnt, oflow_core_i.oflow_core_props_i.fail_cnt, timeouts);
		if (err_cnt == 0 && timeouts == 0 && oflow_core_i.oflow_core_props_i.fail_cnt == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* all.f */
design/oflow_pkg.sv
design/oflow_if.sv
design/oflow_weight_regs.sv
design/oflow_frame_mem.sv
design/oflow_match_pe.sv
design/oflow_track_ctrl.sv
design/oflow_core.sv
test/oflow_core_props.sv
test/oflow_core_checker.sv
test/oflow_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the oflow_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module oflow_core_tb -f all.f -o oflow_sim

# the error limit keeps the run going past the first assertion failure
./obj_dir/oflow_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation ended without a verdict"
	exit 1
fi
